//--- src/irq_macros.svh
// Shared constants for the interrupt core
// APB address and data widths
// Interrupt id width and implemented-line mask
// Register offsets and the mstatus MIE bit position

`ifndef IRQ_MACROS_SVH
`define IRQ_MACROS_SVH

////////////////////
// Widths
////////////////////

`define IRQ_ADDR_W 8
`define IRQ_DATA_W 32
`define IRQ_ID_W 5
`define IRQ_NUM 32

// Software (3), timer (7), external (11) and fast lines 16..31
`define IRQ_IMPL_MASK 32'hFFFF_0888

////////////////////
// Register map
////////////////////

`define REG_MSTATUS 8'h00
`define REG_MIE 8'h04
`define REG_MIP 8'h08
`define REG_IRQ_ID 8'h0C
`define REG_WFI 8'h10
`define REG_STATUS 8'h14

// Global machine interrupt enable inside mstatus
`define MSTATUS_MIE_BIT 3

`endif

//--- src/irq_pkg.sv
// Shared types for the interrupt core
// APB request and response bundles
// Register block to controller configuration
// Controller status back to the registers and sleep unit

`default_nettype none

`include "irq_macros.svh"

package irq_pkg;

  // APB pins from the master
  typedef struct packed {
    logic                   psel;
    logic                   penable;
    logic                   pwrite;
    logic [`IRQ_ADDR_W-1:0] paddr;
    logic [`IRQ_DATA_W-1:0] pwdata;
  } apb_req_t;

  // APB pins back to the master
  typedef struct packed {
    logic [`IRQ_DATA_W-1:0] prdata;
    logic                   pready;
    logic                   pslverr;
  } apb_rsp_t;

  // Enables from the register block
  typedef struct packed {
    logic [`IRQ_NUM-1:0] mie;
    logic                m_irq_enable;
  } irq_cfg_t;

  // Pending word, selected request and wake-up
  typedef struct packed {
    logic [`IRQ_NUM-1:0]  mip;
    logic                 irq_req;
    logic [`IRQ_ID_W-1:0] irq_id;
    logic                 irq_wu;
  } irq_status_t;

endpackage

`default_nettype wire

//--- src/irq_regs.sv
// Control register block with an APB slave port
// Holds mstatus.MIE and mie
// Issues the WFI sleep request pulse
// Read back of mip, selected id and sleep status

`timescale 1ns/1ps
`default_nettype none

`include "irq_macros.svh"

module irq_regs import irq_pkg::*; (
  input  wire logic        clk_i,
  input  wire logic        rst_n_i,

  // APB slave
  input  wire apb_req_t    apb_req_i,
  output apb_rsp_t         apb_rsp_o,

  // From the interrupt controller
  input  wire irq_status_t irq_status_i,

  // From the sleep unit
  input  wire logic        sleep_i,
  input  wire logic        fetch_enabled_i,

  // To the interrupt controller and sleep unit
  output irq_cfg_t         irq_cfg_o,
  output logic             wfi_req_o
);

  // Access phase qualifiers
  logic                   access;
  logic                   wr_en;
  logic                   mapped;

  // Register state
  logic                   mstatus_mie_q;
  logic [`IRQ_NUM-1:0]    mie_q;
  logic                   wfi_req_q;

  // Read mux result
  logic [`IRQ_DATA_W-1:0] rdata;

  ////////////////////
  // Decode
  ////////////////////

  // Access phase of a transfer, always a single cycle
  assign access = apb_req_i.psel & apb_req_i.penable;
  assign wr_en  = access & apb_req_i.pwrite;

  // Offset decode and read data
  always_comb begin
    mapped = 1'b1;
    rdata  = '0;
    case (apb_req_i.paddr)
      `REG_MSTATUS: begin
        rdata[`MSTATUS_MIE_BIT] = mstatus_mie_q;
      end
      `REG_MIE: begin
        rdata = mie_q;
      end
      `REG_MIP: begin
        rdata = irq_status_i.mip;
      end
      `REG_IRQ_ID: begin
        // Request flag on top, id in the low bits
        rdata[`IRQ_DATA_W-1]  = irq_status_i.irq_req;
        rdata[`IRQ_ID_W-1:0]  = irq_status_i.irq_id;
      end
      `REG_WFI: begin
        // Write only, reads as zero
        rdata = '0;
      end
      `REG_STATUS: begin
        rdata[0] = sleep_i;
        rdata[1] = fetch_enabled_i;
      end
      default: begin
        mapped = 1'b0;
      end
    endcase
  end

  ////////////////////
  // Registers
  ////////////////////

  // mstatus keeps only MIE, mie keeps only implemented lines
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      mstatus_mie_q <= 1'b0;
      mie_q         <= '0;
    end else if (wr_en) begin
      if (apb_req_i.paddr == `REG_MSTATUS) begin
        mstatus_mie_q <= apb_req_i.pwdata[`MSTATUS_MIE_BIT];
      end
      if (apb_req_i.paddr == `REG_MIE) begin
        mie_q <= apb_req_i.pwdata & `IRQ_IMPL_MASK;
      end
    end
  end

  // One-cycle sleep request after a WFI write
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wfi_req_q <= 1'b0;
    end else begin
      wfi_req_q <= wr_en && (apb_req_i.paddr == `REG_WFI);
    end
  end

  ////////////////////
  // Outputs
  ////////////////////

  // No wait states
  assign apb_rsp_o.pready  = 1'b1;
  assign apb_rsp_o.prdata  = rdata;
  // Error only in the access phase of an unmapped offset
  assign apb_rsp_o.pslverr = access & ~mapped;

  assign irq_cfg_o.mie          = mie_q;
  assign irq_cfg_o.m_irq_enable = mstatus_mie_q;

  assign wfi_req_o = wfi_req_q;

endmodule

`default_nettype wire

//--- src/irq_int_controller.sv
// Machine-mode interrupt controller
// Registers the implemented lines into mip
// Masks with mie and the global enable
// Fixed priority selection and wake-up detection

`timescale 1ns/1ps
`default_nettype none

`include "irq_macros.svh"

module irq_int_controller import irq_pkg::*; (
  input  wire logic                clk_i,
  input  wire logic                rst_n_i,

  // Raw interrupt lines
  input  wire logic [`IRQ_NUM-1:0] irq_i,

  // Enables from the register block
  input  wire irq_cfg_t            irq_cfg_i,

  // Pending word and selected interrupt
  output irq_status_t              irq_status_o
);

  logic [`IRQ_NUM-1:0]  mip_q;
  logic [`IRQ_NUM-1:0]  irq_en;
  logic                 irq_wu;
  logic                 irq_req;
  logic [`IRQ_ID_W-1:0] irq_id_sel;

  ////////////////////
  // Pending
  ////////////////////

  // Unimplemented lines never show up as pending
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      mip_q <= '0;
    end else begin
      mip_q <= irq_i & `IRQ_IMPL_MASK;
    end
  end

  // Pending and individually enabled
  assign irq_en = mip_q & irq_cfg_i.mie;

  // Wake-up ignores the global enable
  assign irq_wu  = |irq_en;
  assign irq_req = irq_wu & irq_cfg_i.m_irq_enable;

  ////////////////////
  // Priority
  ////////////////////

  // Lowest first, each later hit overrides
  // Order low to high: 7, 3, 11, then 16..31
  always_comb begin
    irq_id_sel = '0;
    if (irq_en[7]) begin
      irq_id_sel = `IRQ_ID_W'(7);
    end
    if (irq_en[3]) begin
      irq_id_sel = `IRQ_ID_W'(3);
    end
    if (irq_en[11]) begin
      irq_id_sel = `IRQ_ID_W'(11);
    end
    // Fast lines, highest index wins
    for (int i = 16; i < `IRQ_NUM; i++) begin
      if (irq_en[i]) begin
        irq_id_sel = `IRQ_ID_W'(i);
      end
    end
  end

  ////////////////////
  // Outputs
  ////////////////////

  assign irq_status_o.mip     = mip_q;
  assign irq_status_o.irq_req = irq_req;
  // Id is zero without a request
  assign irq_status_o.irq_id  = irq_req ? irq_id_sel : '0;
  assign irq_status_o.irq_wu  = irq_wu;

endmodule

`default_nettype wire

//--- src/irq_sleep_unit.sv
// Sleep unit
// Sticky fetch-enable latch
// Awake/sleep state machine driven by WFI and wake-up

`timescale 1ns/1ps
`default_nettype none

`include "irq_macros.svh"

module irq_sleep_unit import irq_pkg::*; (
  input  wire logic clk_i,
  input  wire logic rst_n_i,

  // Fetch enable from outside, sticky once seen
  input  wire logic fetch_enable_i,

  // Sleep request and wake-up
  input  wire logic wfi_req_i,
  input  wire logic irq_wu_i,

  // State out
  output logic      core_sleep_o,
  output logic      fetch_enabled_o
);

  logic fetch_enabled_q;
  logic sleep_q;

  // Stays set until reset
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      fetch_enabled_q <= 1'b0;
    end else if (fetch_enable_i) begin
      fetch_enabled_q <= 1'b1;
    end
  end

  ////////////////////
  // Sleep FSM
  ////////////////////

  // Awake (0) or asleep (1)
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sleep_q <= 1'b0;
    end else if (sleep_q) begin
      // Any enabled pending line wakes the core
      if (irq_wu_i) begin
        sleep_q <= 1'b0;
      end
    end else begin
      // No sleep before fetch starts or with a wake-up already there
      if (wfi_req_i && fetch_enabled_q && !irq_wu_i) begin
        sleep_q <= 1'b1;
      end
    end
  end

  assign core_sleep_o    = sleep_q;
  assign fetch_enabled_o = fetch_enabled_q;

endmodule

`default_nettype wire

//--- src/irq_core_top.sv
// Top level of the interrupt core
// APB pin bundling
// Register block, interrupt controller and sleep unit

`timescale 1ns/1ps
`default_nettype none

`include "irq_macros.svh"

module irq_core_top import irq_pkg::*; (
  input  wire logic                   clk_i,
  input  wire logic                   rst_n_i,

  // APB slave
  input  wire logic                   psel_i,
  input  wire logic                   penable_i,
  input  wire logic                   pwrite_i,
  input  wire logic [`IRQ_ADDR_W-1:0] paddr_i,
  input  wire logic [`IRQ_DATA_W-1:0] pwdata_i,
  output logic      [`IRQ_DATA_W-1:0] prdata_o,
  output logic                        pready_o,
  output logic                        pslverr_o,

  // Interrupt lines and fetch control
  input  wire logic [`IRQ_NUM-1:0]    irq_i,
  input  wire logic                   fetch_enable_i,

  // To the pipeline
  output logic                        irq_req_o,
  output logic      [`IRQ_ID_W-1:0]   irq_id_o,
  output logic                        core_sleep_o
);

  apb_req_t    apb_req;
  apb_rsp_t    apb_rsp;
  irq_cfg_t    irq_cfg;
  irq_status_t irq_status;
  logic        wfi_req;
  logic        fetch_enabled;

  ////////////////////
  // APB bundling
  ////////////////////

  assign apb_req.psel    = psel_i;
  assign apb_req.penable = penable_i;
  assign apb_req.pwrite  = pwrite_i;
  assign apb_req.paddr   = paddr_i;
  assign apb_req.pwdata  = pwdata_i;

  assign prdata_o  = apb_rsp.prdata;
  assign pready_o  = apb_rsp.pready;
  assign pslverr_o = apb_rsp.pslverr;

  // Selected interrupt to the pipeline
  assign irq_req_o = irq_status.irq_req;
  assign irq_id_o  = irq_status.irq_id;

  ////////////////////
  // Instances
  ////////////////////

  irq_regs irq_regs_inst (
    .clk_i           ( clk_i         ),
    .rst_n_i         ( rst_n_i       ),
    .apb_req_i       ( apb_req       ),
    .apb_rsp_o       ( apb_rsp       ),
    .irq_status_i    ( irq_status    ),
    .sleep_i         ( core_sleep_o  ),
    .fetch_enabled_i ( fetch_enabled ),
    .irq_cfg_o       ( irq_cfg       ),
    .wfi_req_o       ( wfi_req       )
  );

  irq_int_controller irq_int_controller_inst (
    .clk_i           ( clk_i         ),
    .rst_n_i         ( rst_n_i       ),
    .irq_i           ( irq_i         ),
    .irq_cfg_i       ( irq_cfg       ),
    .irq_status_o    ( irq_status    )
  );

  irq_sleep_unit irq_sleep_unit_inst (
    .clk_i           ( clk_i             ),
    .rst_n_i         ( rst_n_i           ),
    .fetch_enable_i  ( fetch_enable_i    ),
    .wfi_req_i       ( wfi_req           ),
    .irq_wu_i        ( irq_status.irq_wu ),
    .core_sleep_o    ( core_sleep_o      ),
    .fetch_enabled_o ( fetch_enabled     )
  );

endmodule

`default_nettype wire

//--- test/tb_clk_gen.sv
// Testbench clock and reset
// 40 ns clock period
// Active-low reset held for the first 10 rising edges

`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  // Half period of 20 ns
  initial begin
    clk_o = 1'b0;
    forever #20 clk_o = ~clk_o;
  end

  // Release after 10 cycles
  initial begin
    rst_n_o <= 1'b0;
    repeat (10) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

`default_nettype wire

//--- test/tb_irq_core.sv
// Testbench for the interrupt core top level
// Reads one operation per line from the vector file
// Drives the APB port, the interrupt lines and fetch enable
// Checks read data, error flag, selected interrupt and sleep state

`timescale 1ns/1ps
`default_nettype none

`include "irq_macros.svh"

module tb_irq_core;

  localparam string VEC_FILE      = "test/irq_input_vectors.txt";
  localparam int    WAIT_CYCLES   = 4;
  localparam int    RESET_TIMEOUT = 50;
  localparam int    MAX_OPS       = 1000;

  logic                   clk;
  logic                   rst_n;
  logic                   psel;
  logic                   penable;
  logic                   pwrite;
  logic [`IRQ_ADDR_W-1:0] paddr;
  logic [`IRQ_DATA_W-1:0] pwdata;
  logic [`IRQ_DATA_W-1:0] prdata;
  logic                   pready;
  logic                   pslverr;
  logic [`IRQ_NUM-1:0]    irq;
  logic                   fetch_en;
  logic                   irq_req;
  logic [`IRQ_ID_W-1:0]   irq_id;
  logic                   core_sleep;

  int error_count;
  int check_count;
  int op_count;

  tb_clk_gen tb_clk_gen_inst (
    .clk_o   ( clk   ),
    .rst_n_o ( rst_n )
  );

  irq_core_top irq_core_top_inst (
    .clk_i          ( clk        ),
    .rst_n_i        ( rst_n      ),
    .psel_i         ( psel       ),
    .penable_i      ( penable    ),
    .pwrite_i       ( pwrite     ),
    .paddr_i        ( paddr      ),
    .pwdata_i       ( pwdata     ),
    .prdata_o       ( prdata     ),
    .pready_o       ( pready     ),
    .pslverr_o      ( pslverr    ),
    .irq_i          ( irq        ),
    .fetch_enable_i ( fetch_en   ),
    .irq_req_o      ( irq_req    ),
    .irq_id_o       ( irq_id     ),
    .core_sleep_o   ( core_sleep )
  );

  ////////////////////
  // Helpers
  ////////////////////

  // One value against its expectation
  task automatic compare_value(input string sig_name, input logic [31:0] got,
                               input logic [31:0] expected);
    check_count++;
    assert (got === expected) else begin
      error_count++;
      $display("[ERROR] %0t ns %s: got %h, expected %h", $time, sig_name, got, expected);
    end
  endtask

  // Setup phase, then access phase until pready
  task automatic apb_transfer(input logic wr, input logic [`IRQ_ADDR_W-1:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
    int cycles;
    cycles = 0;
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= wr;
    paddr   <= addr;
    pwdata  <= wdata;
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk);
    while (pready !== 1'b1 && cycles < WAIT_CYCLES) begin
      @(negedge clk);
      cycles++;
    end
    assert (pready === 1'b1) else begin
      error_count++;
      $display("APB transfer to offset %h never saw pready", addr);
    end
    // Sampled mid-cycle, away from the clock edge
    rdata = prdata;
    err   = pslverr;
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
  endtask

  // Wait a few cycles for the expected request and id
  task automatic expect_irq(input logic exp_req, input logic [`IRQ_ID_W-1:0] exp_id);
    int cycles;
    cycles = 0;
    // Lines reach mip one edge after they change
    @(posedge clk);
    @(negedge clk);
    while ((irq_req !== exp_req || irq_id !== exp_id) && cycles < WAIT_CYCLES) begin
      @(negedge clk);
      cycles++;
    end
    compare_value("irq_req_o", {31'b0, irq_req}, {31'b0, exp_req});
    compare_value("irq_id_o", {27'b0, irq_id}, {27'b0, exp_id});
  endtask

  task automatic expect_sleep(input logic exp_sleep);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (core_sleep !== exp_sleep && cycles < WAIT_CYCLES) begin
      @(negedge clk);
      cycles++;
    end
    compare_value("core_sleep_o", {31'b0, core_sleep}, {31'b0, exp_sleep});
  endtask

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    int          fd;
    int          code;
    int          cycles;
    logic [7:0]  op;
    logic [31:0] f_addr;
    logic [31:0] f_data;
    logic [31:0] f_flag;
    logic [31:0] rdata;
    logic        err;

    error_count = 0;
    check_count = 0;
    op_count    = 0;
    cycles      = 0;
    psel     <= 1'b0;
    penable  <= 1'b0;
    pwrite   <= 1'b0;
    paddr    <= '0;
    pwdata   <= '0;
    irq      <= '0;
    fetch_en <= 1'b0;

    while (rst_n !== 1'b1 && cycles < RESET_TIMEOUT) begin
      @(posedge clk);
      cycles++;
    end
    assert (rst_n === 1'b1) else begin
      error_count++;
      $display("Reset was never released");
    end

    fd = $fopen(VEC_FILE, "r");
    assert (fd != 0) else begin
      error_count++;
      $display("Could not open the vector file %s", VEC_FILE);
    end

    // Columns: operation, offset, data, flag
    if (fd != 0) begin
      while (!$feof(fd) && op_count < MAX_OPS) begin
        code = $fscanf(fd, " %c %h %h %h", op, f_addr, f_data, f_flag);
        if (code != 4) begin
          assert ($feof(fd)) else begin
            error_count++;
            $display("Malformed vector line after operation %0d", op_count);
          end
          break;
        end
        op_count++;
        case (op)
          "W": begin
            apb_transfer(1'b1, f_addr[7:0], f_data, rdata, err);
            compare_value("pslverr_o", {31'b0, err}, f_flag);
          end
          "R": begin
            apb_transfer(1'b0, f_addr[7:0], 32'd0, rdata, err);
            compare_value("prdata_o", rdata, f_data);
            compare_value("pslverr_o", {31'b0, err}, f_flag);
          end
          "I": begin
            @(posedge clk);
            irq <= f_data;
          end
          "F": begin
            @(posedge clk);
            fetch_en <= f_flag[0];
          end
          "E": expect_irq(f_flag[0], f_data[4:0]);
          "S": expect_sleep(f_flag[0]);
          default: begin
            assert (1'b0) else begin
              error_count++;
              $display("Unknown operation code %h in the vector file", op);
            end
          end
        endcase
      end
      $fclose(fd);
    end

    assert (op_count > 0) else begin
      error_count++;
      $display("No operations were read from the vector file");
    end

    $display("Operations: %0d, checks: %0d, errors: %0d", op_count, check_count, error_count);
    if (error_count == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- test/irq_input_vectors.txt
W 00 FFFFFFFF 0
R 00 00000008 0
W 00 00000000 0
W 04 FFFFFFFF 0
R 04 FFFF0888 0
R 20 00000000 1
R 18 00000000 1
R 10 00000000 0
W 10 00000000 0
R 14 00000000 0
S 00 00000000 0
I 00 FFFFFFFF 0
E 00 00000000 0
R 08 FFFF0888 0
W 08 00000000 0
R 08 FFFF0888 0
R 0C 00000000 0
I 00 00000000 0
F 00 00000000 1
W 00 00000008 0
I 00 00100888 0
E 00 00000014 1
R 0C 80000014 0
I 00 00000888 0
E 00 0000000B 1
I 00 00000088 0
E 00 00000003 1
I 00 00000080 0
E 00 00000007 1
R 0C 80000007 0
I 00 00000000 0
E 00 00000000 0
W 00 00000000 0
W 10 00000000 0
S 00 00000000 1
R 14 00000003 0
I 00 00010000 0
S 00 00000000 0
E 00 00000000 0
R 14 00000002 0
W 10 00000000 0
R 14 00000002 0
I 00 00000000 0

//--- tb.f
+incdir+src
src/irq_pkg.sv
src/irq_regs.sv
src/irq_int_controller.sv
src/irq_sleep_unit.sv
src/irq_core_top.sv
test/tb_clk_gen.sv
test/tb_irq_core.sv

//--- run.sh
#!/usr/bin/env bash
# Build with Verilator, run, and pass only if the pass message shows up
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_irq_core -f tb.f -o tb_irq_core \
  && ./obj_dir/tb_irq_core | tee /dev/stderr | grep -q -x "Everything OK" \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
